//--- include/decode_settings.svh
// Widths are fixed for the 32-bit core, so changing them also means moving the instruction fields.
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// data path and program counter width.
`define DATA_W 32

// register number width and register count, which must agree.
`define REG_ADDR_W 5
`define REG_COUNT 32

`define OPCODE_W 6 // top bits of every instruction.

`endif

//--- source/decode_pkg.sv
// Enum encodings must match the execute stage, and any opcode not listed here decodes as a NOP.
`include "decode_settings.svh"

package decode_pkg;

	// the opcode sits in bits 31 to 26 and dest in bits 25 to 21.
	// src1 is bits 20 to 16 and src2 is bits 15 to 11.
	// the immediate overlaps src2 and is bits 15 to 0, sign-extended.
	localparam int opcode_lsb = 26;
	localparam int dest_lsb = 21;
	localparam int src1_lsb = 16;
	localparam int src2_lsb = 11;
	localparam int imm_w = 16;

	localparam logic [`OPCODE_W-1:0] op_nop = 'd0;
	localparam logic [`OPCODE_W-1:0] op_add = 'd1;
	localparam logic [`OPCODE_W-1:0] op_sub = 'd2;
	localparam logic [`OPCODE_W-1:0] op_and = 'd3;
	localparam logic [`OPCODE_W-1:0] op_or = 'd4;
	localparam logic [`OPCODE_W-1:0] op_xor = 'd5;
	localparam logic [`OPCODE_W-1:0] op_sll = 'd6;
	localparam logic [`OPCODE_W-1:0] op_srl = 'd7;
	localparam logic [`OPCODE_W-1:0] op_addi = 'd8;
	localparam logic [`OPCODE_W-1:0] op_subi = 'd9;
	localparam logic [`OPCODE_W-1:0] op_ld = 'd10; // address is src1 plus immediate.
	localparam logic [`OPCODE_W-1:0] op_st = 'd11; // store value comes from the dest field.
	localparam logic [`OPCODE_W-1:0] op_bez = 'd12;
	localparam logic [`OPCODE_W-1:0] op_bne = 'd13; // compares src1 against the dest field.
	localparam logic [`OPCODE_W-1:0] op_jmp = 'd14;

	typedef enum logic [3:0]
	{
		exe_nop = 4'd0,
		exe_add = 4'd1,
		exe_sub = 4'd2,
		exe_and = 4'd3,
		exe_or = 4'd4,
		exe_xor = 4'd5,
		exe_sll = 4'd6,
		exe_srl = 4'd7
	} exe_cmd_t;

	typedef enum logic [1:0]
	{
		br_none = 2'd0,
		br_bez = 2'd1,
		br_bne = 2'd2,
		br_jmp = 2'd3
	} br_type_t;

endpackage

//--- source/control_decoder.sv
// Purely combinational, and every branch and memory opcode uses the immediate as operand b.
`timescale 1ns/100ps
`include "decode_settings.svh"

module control_decoder
(
	input logic [`DATA_W-1:0] instr,
	output logic [`REG_ADDR_W-1:0] src1_addr,
	output logic [`REG_ADDR_W-1:0] src2_addr,
	output logic [`REG_ADDR_W-1:0] dest_addr,
	output decode_pkg::exe_cmd_t exe_cmd,
	output decode_pkg::br_type_t br_type,
	output logic is_imm,
	output logic wb_en,
	output logic mem_r_en,
	output logic mem_w_en,
	output logic uses_src2
);

	logic [`OPCODE_W-1:0] opcode;
	logic src2_from_dest;

	assign opcode = instr[decode_pkg::opcode_lsb +: `OPCODE_W];
	assign dest_addr = instr[decode_pkg::dest_lsb +: `REG_ADDR_W];
	assign src1_addr = instr[decode_pkg::src1_lsb +: `REG_ADDR_W];

	// stores and bne read their second register through the dest field.
	assign src2_from_dest = (opcode == decode_pkg::op_st) || (opcode == decode_pkg::op_bne);
	assign src2_addr = src2_from_dest ? dest_addr : instr[decode_pkg::src2_lsb +: `REG_ADDR_W];

	always_comb
	begin
		case (opcode)
			decode_pkg::op_add: exe_cmd = decode_pkg::exe_add;
			decode_pkg::op_sub: exe_cmd = decode_pkg::exe_sub;
			decode_pkg::op_and: exe_cmd = decode_pkg::exe_and;
			decode_pkg::op_or: exe_cmd = decode_pkg::exe_or;
			decode_pkg::op_xor: exe_cmd = decode_pkg::exe_xor;
			decode_pkg::op_sll: exe_cmd = decode_pkg::exe_sll;
			decode_pkg::op_srl: exe_cmd = decode_pkg::exe_srl;
			decode_pkg::op_addi: exe_cmd = decode_pkg::exe_add;
			decode_pkg::op_subi: exe_cmd = decode_pkg::exe_sub;
			decode_pkg::op_ld: exe_cmd = decode_pkg::exe_add; // address calculation.
			decode_pkg::op_st: exe_cmd = decode_pkg::exe_add;
			default: exe_cmd = decode_pkg::exe_nop;
		endcase
	end

	always_comb
	begin
		br_type = decode_pkg::br_none;
		is_imm = 1'b0;
		wb_en = 1'b0;
		mem_r_en = 1'b0;
		mem_w_en = 1'b0;
		uses_src2 = 1'b0;
		case (opcode)
			decode_pkg::op_add, decode_pkg::op_sub, decode_pkg::op_and, decode_pkg::op_or,
			decode_pkg::op_xor, decode_pkg::op_sll, decode_pkg::op_srl:
			begin
				wb_en = 1'b1;
				uses_src2 = 1'b1;
			end
			decode_pkg::op_addi, decode_pkg::op_subi:
			begin
				wb_en = 1'b1;
				is_imm = 1'b1;
			end
			decode_pkg::op_ld:
			begin
				wb_en = 1'b1;
				mem_r_en = 1'b1;
				is_imm = 1'b1;
			end
			decode_pkg::op_st:
			begin
				mem_w_en = 1'b1;
				is_imm = 1'b1;
				uses_src2 = 1'b1;
			end
			decode_pkg::op_bez:
			begin
				br_type = decode_pkg::br_bez;
				is_imm = 1'b1; // branch offset.
			end
			decode_pkg::op_bne:
			begin
				br_type = decode_pkg::br_bne;
				is_imm = 1'b1;
				uses_src2 = 1'b1;
			end
			decode_pkg::op_jmp:
			begin
				br_type = decode_pkg::br_jmp;
				is_imm = 1'b1;
			end
			default:
			begin
				// nop and undefined opcodes keep every control inactive.
			end
		endcase
	end

endmodule

//--- source/register_file.sv
// Register 0 always reads zero and a read of the register being written returns the new value.
`timescale 1ns/100ps
`include "decode_settings.svh"

module register_file
(
	input logic clk,
	input logic arst_n,
	input logic wb_en,
	input logic [`REG_ADDR_W-1:0] wb_dest,
	input logic [`REG_ADDR_W-1:0] read1_addr,
	input logic [`REG_ADDR_W-1:0] read2_addr,
	input logic [`DATA_W-1:0] wb_value,
	output logic [`DATA_W-1:0] read1,
	output logic [`DATA_W-1:0] read2
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];
	logic write_ok;
	logic bypass1;
	logic bypass2;

	assign write_ok = wb_en && (wb_dest != '0); // writes to register 0 are dropped.

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (write_ok)
		begin
			regs[wb_dest] <= wb_value;
		end
	end

	// write-through so that decode sees a value retiring in this same cycle.
	assign bypass1 = write_ok && (wb_dest == read1_addr);
	assign bypass2 = write_ok && (wb_dest == read2_addr);

	assign read1 = (read1_addr == '0) ? '0 :
		bypass1 ? wb_value : regs[read1_addr];
	assign read2 = (read2_addr == '0) ? '0 :
		bypass2 ? wb_value : regs[read2_addr];

endmodule

//--- source/hazard_unit.sv
// Detects load-use hazards only, since forwarding is assumed to cover every other dependency.
`timescale 1ns/100ps
`include "decode_settings.svh"

module hazard_unit
(
	input logic [`REG_ADDR_W-1:0] src1_addr,
	input logic [`REG_ADDR_W-1:0] src2_addr,
	input logic [`REG_ADDR_W-1:0] ex_dest,
	input logic uses_src2,
	input logic ex_mem_r_en,
	output logic stall
);

	logic load_in_ex;
	logic src1_match;
	logic src2_match;

	// a load into register 0 never creates a dependency.
	assign load_in_ex = ex_mem_r_en && (ex_dest != '0);

	assign src1_match = (src1_addr == ex_dest);
	assign src2_match = uses_src2 && (src2_addr == ex_dest); // immediate forms skip src2.

	// the bubble that follows clears ex_mem_r_en, so this lasts one cycle.
	assign stall = load_in_ex && (src1_match || src2_match);

endmodule

//--- source/id_stage_reg.sv
// Stall and branch_taken both load a bubble on the next edge, and a bubble is all zeros.
`timescale 1ns/100ps
`include "decode_settings.svh"

module id_stage_reg
(
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic branch_taken,
	input logic [`REG_ADDR_W-1:0] src1_in,
	input logic [`REG_ADDR_W-1:0] src2_in,
	input logic [`REG_ADDR_W-1:0] dest_in,
	input logic [`DATA_W-1:0] readdata1_in,
	input logic [`DATA_W-1:0] readdata2_in,
	input logic [`DATA_W-1:0] immediate_in,
	input logic [`DATA_W-1:0] operand_b_in,
	input logic is_imm_in,
	input logic wb_en_in,
	input logic mem_r_en_in,
	input logic mem_w_en_in,
	input decode_pkg::br_type_t br_type_in,
	input decode_pkg::exe_cmd_t exe_cmd_in,
	input logic [`DATA_W-1:0] pc_in,
	output logic [`REG_ADDR_W-1:0] src1,
	output logic [`REG_ADDR_W-1:0] src2,
	output logic [`REG_ADDR_W-1:0] dest,
	output logic [`DATA_W-1:0] readdata1,
	output logic [`DATA_W-1:0] readdata2,
	output logic [`DATA_W-1:0] immediate,
	output logic [`DATA_W-1:0] operand_b,
	output logic is_imm,
	output logic wb_en,
	output logic mem_r_en,
	output logic mem_w_en,
	output decode_pkg::br_type_t br_type,
	output decode_pkg::exe_cmd_t exe_cmd,
	output logic [`DATA_W-1:0] pc
);

	logic flush;

	assign flush = stall || branch_taken;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			src1 <= '0;
			src2 <= '0;
			dest <= '0;
			readdata1 <= '0;
			readdata2 <= '0;
			immediate <= '0;
			operand_b <= '0;
			is_imm <= 1'b0;
			wb_en <= 1'b0;
			mem_r_en <= 1'b0;
			mem_w_en <= 1'b0;
			br_type <= decode_pkg::br_none;
			exe_cmd <= decode_pkg::exe_nop;
			pc <= '0;
		end
		else
		begin
			src1 <= flush ? '0 : src1_in;
			src2 <= flush ? '0 : src2_in;
			dest <= flush ? '0 : dest_in;
			readdata1 <= flush ? '0 : readdata1_in;
			readdata2 <= flush ? '0 : readdata2_in;
			immediate <= flush ? '0 : immediate_in;
			operand_b <= flush ? '0 : operand_b_in;
			is_imm <= flush ? 1'b0 : is_imm_in;
			wb_en <= flush ? 1'b0 : wb_en_in;
			mem_r_en <= flush ? 1'b0 : mem_r_en_in; // also releases the load-use stall.
			mem_w_en <= flush ? 1'b0 : mem_w_en_in;
			br_type <= flush ? decode_pkg::br_none : br_type_in;
			exe_cmd <= flush ? decode_pkg::exe_nop : exe_cmd_in;
			pc <= flush ? '0 : pc_in;
		end
	end

endmodule

//--- source/decode_stage.sv
// Fetch must hold instr and pc while stall is high, and there is no forwarding in this stage.
`timescale 1ns/100ps
`include "decode_settings.svh"

module decode_stage
(
	input logic clk,
	input logic arst_n,
	input logic [`DATA_W-1:0] instr,
	input logic [`DATA_W-1:0] pc,
	input logic wb_en,
	input logic [`REG_ADDR_W-1:0] wb_dest,
	input logic [`DATA_W-1:0] wb_value,
	input logic branch_taken,
	output logic stall,
	output logic [`REG_ADDR_W-1:0] src1,
	output logic [`REG_ADDR_W-1:0] src2,
	output logic [`REG_ADDR_W-1:0] dest,
	output logic [`DATA_W-1:0] readdata1,
	output logic [`DATA_W-1:0] readdata2,
	output logic [`DATA_W-1:0] immediate,
	output logic [`DATA_W-1:0] operand_b,
	output logic is_imm,
	output logic wb_en_ex,
	output logic mem_r_en,
	output logic mem_w_en,
	output decode_pkg::br_type_t br_type,
	output decode_pkg::exe_cmd_t exe_cmd,
	output logic [`DATA_W-1:0] pc_ex
);

	logic [`REG_ADDR_W-1:0] src1_addr;
	logic [`REG_ADDR_W-1:0] src2_addr;
	logic [`REG_ADDR_W-1:0] dest_addr;
	decode_pkg::exe_cmd_t dec_exe_cmd;
	decode_pkg::br_type_t dec_br_type;
	logic dec_is_imm;
	logic dec_wb_en;
	logic dec_mem_r_en;
	logic dec_mem_w_en;
	logic uses_src2;
	logic [`DATA_W-1:0] read1;
	logic [`DATA_W-1:0] read2;
	logic [`DATA_W-1:0] imm_ext;
	logic [`DATA_W-1:0] op_b;

	control_decoder control_decoder_inst
	(
		.instr(instr),
		.src1_addr(src1_addr),
		.src2_addr(src2_addr),
		.dest_addr(dest_addr),
		.exe_cmd(dec_exe_cmd),
		.br_type(dec_br_type),
		.is_imm(dec_is_imm),
		.wb_en(dec_wb_en),
		.mem_r_en(dec_mem_r_en),
		.mem_w_en(dec_mem_w_en),
		.uses_src2(uses_src2)
	);

	register_file register_file_inst
	(
		.clk(clk),
		.arst_n(arst_n),
		.wb_en(wb_en),
		.wb_dest(wb_dest),
		.read1_addr(src1_addr),
		.read2_addr(src2_addr),
		.wb_value(wb_value),
		.read1(read1),
		.read2(read2)
	);

	// the execute stage's load is whatever sits in the ID/EX register now.
	hazard_unit hazard_unit_inst
	(
		.src1_addr(src1_addr),
		.src2_addr(src2_addr),
		.ex_dest(dest),
		.uses_src2(uses_src2),
		.ex_mem_r_en(mem_r_en),
		.stall(stall)
	);

	assign imm_ext = {{(`DATA_W - decode_pkg::imm_w){instr[decode_pkg::imm_w-1]}},
		instr[decode_pkg::imm_w-1:0]};
	assign op_b = dec_is_imm ? imm_ext : read2; // second ALU operand.

	id_stage_reg id_stage_reg_inst
	(
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.branch_taken(branch_taken),
		.src1_in(src1_addr),
		.src2_in(src2_addr),
		.dest_in(dest_addr),
		.readdata1_in(read1),
		.readdata2_in(read2),
		.immediate_in(imm_ext),
		.operand_b_in(op_b),
		.is_imm_in(dec_is_imm),
		.wb_en_in(dec_wb_en),
		.mem_r_en_in(dec_mem_r_en),
		.mem_w_en_in(dec_mem_w_en),
		.br_type_in(dec_br_type),
		.exe_cmd_in(dec_exe_cmd),
		.pc_in(pc),
		.src1(src1),
		.src2(src2),
		.dest(dest),
		.readdata1(readdata1),
		.readdata2(readdata2),
		.immediate(immediate),
		.operand_b(operand_b),
		.is_imm(is_imm),
		.wb_en(wb_en_ex),
		.mem_r_en(mem_r_en),
		.mem_w_en(mem_w_en),
		.br_type(br_type),
		.exe_cmd(exe_cmd),
		.pc(pc_ex)
	);

endmodule

//--- bench/decode_stage_asserts.sv
// Bound to every decode_stage instance and samples only the ID/EX enables and the stall level.
`timescale 1ns/100ps

module decode_stage_asserts
(
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic branch_taken,
	input logic wb_en_ex,
	input logic mem_r_en,
	input logic mem_w_en
);

	// the first edge after reset sees a cleared ID/EX register.
	a_reset_idle: assert property (@(posedge clk)
		$rose(arst_n) |-> (!wb_en_ex && !mem_r_en && !mem_w_en))
		else $error("enables active right after reset");

	a_flush_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		(stall || branch_taken) |=> (!wb_en_ex && !mem_r_en && !mem_w_en))
		else $error("stall or branch did not produce a bubble");

	a_stall_once: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> !stall)
		else $error("stall held for two cycles in a row"); // bubble clears mem_r_en.

endmodule

bind decode_stage decode_stage_asserts decode_stage_asserts_inst
(
	.clk(clk),
	.arst_n(arst_n),
	.stall(stall),
	.branch_taken(branch_taken),
	.wb_en_ex(wb_en_ex),
	.mem_r_en(mem_r_en),
	.mem_w_en(mem_w_en)
);

//--- bench/decode_stage_tb.sv
// Drives one table row per clock and checks the ID/EX outputs one cycle later, with no forwarding.
`timescale 1ns/100ps
`include "decode_settings.svh"

module decode_stage_tb;

	localparam int row_count = 15;
	localparam int clk_period = 100;

	logic clk;
	logic arst_n;
	logic [`DATA_W-1:0] instr;
	logic [`DATA_W-1:0] pc;
	logic wb_en;
	logic [`REG_ADDR_W-1:0] wb_dest;
	logic [`DATA_W-1:0] wb_value;
	logic branch_taken;
	logic stall;
	logic [`REG_ADDR_W-1:0] src1;
	logic [`REG_ADDR_W-1:0] src2;
	logic [`REG_ADDR_W-1:0] dest;
	logic [`DATA_W-1:0] readdata1;
	logic [`DATA_W-1:0] readdata2;
	logic [`DATA_W-1:0] immediate;
	logic [`DATA_W-1:0] operand_b;
	logic is_imm;
	logic wb_en_ex;
	logic mem_r_en;
	logic mem_w_en;
	decode_pkg::br_type_t br_type;
	decode_pkg::exe_cmd_t exe_cmd;
	logic [`DATA_W-1:0] pc_ex;

	// each row holds one cycle of stimulus, the stall in that cycle and the next ID/EX contents.
	logic [`DATA_W-1:0] t_instr [row_count];
	logic [`DATA_W-1:0] t_pc [row_count];
	logic t_wb_en [row_count];
	logic [`REG_ADDR_W-1:0] t_wb_dest [row_count];
	logic [`DATA_W-1:0] t_wb_value [row_count];
	logic t_branch [row_count];
	logic t_stall [row_count];
	logic t_bubble [row_count];
	logic [`REG_ADDR_W-1:0] t_src2 [row_count];
	logic [`DATA_W-1:0] t_rd1 [row_count];
	logic [`DATA_W-1:0] t_rd2 [row_count];
	logic [9:0] t_ctrl [row_count]; // packs is_imm, wb, mem read, mem write, branch and ALU command.
	int fill;

	decode_stage decode_stage_inst
	(
		.clk(clk),
		.arst_n(arst_n),
		.instr(instr),
		.pc(pc),
		.wb_en(wb_en),
		.wb_dest(wb_dest),
		.wb_value(wb_value),
		.branch_taken(branch_taken),
		.stall(stall),
		.src1(src1),
		.src2(src2),
		.dest(dest),
		.readdata1(readdata1),
		.readdata2(readdata2),
		.immediate(immediate),
		.operand_b(operand_b),
		.is_imm(is_imm),
		.wb_en_ex(wb_en_ex),
		.mem_r_en(mem_r_en),
		.mem_w_en(mem_w_en),
		.br_type(br_type),
		.exe_cmd(exe_cmd),
		.pc_ex(pc_ex)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		#((row_count + 10) * clk_period);
		$display("Timeout: the table did not finish in the expected number of cycles.");
		$display("Test failed");
		$fatal(1);
	end

	// low 16 bits carry either the immediate or {src2, 11 zero bits}.
	function automatic logic [31:0] enc(logic [5:0] op, logic [4:0] d, logic [4:0] s1,
		logic [15:0] low);
		return {op, d, s1, low};
	endfunction

	function automatic logic [9:0] ctrl(logic imm, logic wb, logic mr, logic mw,
		logic [1:0] br, logic [3:0] cmd);
		return {imm, wb, mr, mw, br, cmd};
	endfunction

	task automatic add_row(logic [31:0] ins, logic [31:0] p, logic we, logic [4:0] wd,
		logic [31:0] wv, logic bt, logic st, logic bub, logic [4:0] s2, logic [31:0] r1,
		logic [31:0] r2, logic [9:0] c);
		t_instr[fill] = ins;
		t_pc[fill] = p;
		t_wb_en[fill] = we;
		t_wb_dest[fill] = wd;
		t_wb_value[fill] = wv;
		t_branch[fill] = bt;
		t_stall[fill] = st;
		t_bubble[fill] = bub;
		t_src2[fill] = s2;
		t_rd1[fill] = r1;
		t_rd2[fill] = r2;
		t_ctrl[fill] = c;
		fill++;
	endtask

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// r below zero or a bubble row means every ID/EX field must be zero.
	task automatic check_idex(int r);
		logic [31:0] ins;
		logic [31:0] imm;
		logic [9:0] c;
		logic zero;
		zero = (r < 0) ? 1'b1 : t_bubble[r];
		ins = zero ? '0 : t_instr[r];
		c = zero ? '0 : t_ctrl[r];
		imm = 32'(ins[15:0]);
		if (ins[15])
			imm = imm - 32'h10000; // the 16-bit field is a two's complement value.
		check("src1", 32'(src1), 32'(ins[20:16]));
		check("dest", 32'(dest), 32'(ins[25:21]));
		check("src2", 32'(src2), zero ? 32'd0 : 32'(t_src2[r]));
		check("readdata1", readdata1, zero ? 32'd0 : t_rd1[r]);
		check("readdata2", readdata2, zero ? 32'd0 : t_rd2[r]);
		check("immediate", immediate, imm);
		check("operand_b", operand_b, c[9] ? imm : (zero ? 32'd0 : t_rd2[r]));
		check("is_imm", 32'(is_imm), 32'(c[9]));
		check("wb_en_ex", 32'(wb_en_ex), 32'(c[8]));
		check("mem_r_en", 32'(mem_r_en), 32'(c[7]));
		check("mem_w_en", 32'(mem_w_en), 32'(c[6]));
		check("br_type", 32'(br_type), 32'(c[5:4]));
		check("exe_cmd", 32'(exe_cmd), 32'(c[3:0]));
		check("pc_ex", pc_ex, zero ? 32'd0 : t_pc[r]);
	endtask

	initial
	begin
		logic [9:0] c_add;
		logic [9:0] c_ld;
		c_add = ctrl(1'b0, 1'b1, 1'b0, 1'b0, 2'd0, 4'd1);
		c_ld = ctrl(1'b1, 1'b1, 1'b1, 1'b0, 2'd0, 4'd1);
		fill = 0;
		arst_n = 1'b0;
		instr = '0;
		pc = '0;
		wb_en = 1'b0;
		wb_dest = '0;
		wb_value = '0;
		branch_taken = 1'b0;

		add_row(32'h0, 32'h100, 1, 5'd1, 32'h11111111, 0, 0, 0, 5'd0, 32'h0, 32'h0, 10'h0);
		add_row(enc(6'd1, 5'd3, 5'd1, 16'h1000), 32'h104, 1, 5'd2, 32'h22222222, 0, 0, 0,
			5'd2, 32'h11111111, 32'h22222222, c_add); // r2 arrives by write-through.
		add_row(enc(6'd2, 5'd4, 5'd0, 16'h0800), 32'h108, 1, 5'd0, 32'hdeadbeef, 0, 0, 0,
			5'd1, 32'h0, 32'h11111111, ctrl(0, 1, 0, 0, 2'd0, 4'd2));
		add_row(enc(6'd8, 5'd6, 5'd1, 16'h7fff), 32'h10c, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd15, 32'h11111111, 32'h0, ctrl(1, 1, 0, 0, 2'd0, 4'd1));
		add_row(enc(6'd9, 5'd7, 5'd2, 16'h8000), 32'h110, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd16, 32'h22222222, 32'h0, ctrl(1, 1, 0, 0, 2'd0, 4'd2));
		add_row(enc(6'd10, 5'd8, 5'd1, 16'h0004), 32'h114, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd0, 32'h11111111, 32'h0, c_ld);
		// add needs r8 from the load in execute, so it stalls and is presented again.
		add_row(enc(6'd1, 5'd9, 5'd8, 16'h1000), 32'h118, 0, 5'd0, 32'h0, 0, 1, 1,
			5'd2, 32'h0, 32'h0, 10'h0);
		add_row(enc(6'd1, 5'd9, 5'd8, 16'h1000), 32'h118, 1, 5'd8, 32'h88888888, 0, 0, 0,
			5'd2, 32'h88888888, 32'h22222222, c_add);
		add_row(enc(6'd10, 5'd10, 5'd2, 16'h0010), 32'h11c, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd0, 32'h22222222, 32'h0, c_ld);
		add_row(enc(6'd5, 5'd11, 5'd1, 16'h1000), 32'h120, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd2, 32'h11111111, 32'h22222222, ctrl(0, 1, 0, 0, 2'd0, 4'd5));
		add_row(enc(6'd8, 5'd12, 5'd1, 16'h0005), 32'h124, 0, 5'd0, 32'h0, 1, 0, 1,
			5'd0, 32'h0, 32'h0, 10'h0);
		add_row(enc(6'd11, 5'd2, 5'd1, 16'h0008), 32'h128, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd2, 32'h11111111, 32'h22222222, ctrl(1, 0, 0, 1, 2'd0, 4'd1));
		add_row(enc(6'd13, 5'd1, 5'd2, 16'hfffc), 32'h12c, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd1, 32'h22222222, 32'h11111111, ctrl(1, 0, 0, 0, 2'd2, 4'd0));
		add_row(enc(6'd63, 5'd3, 5'd1, 16'h1000), 32'h130, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd2, 32'h11111111, 32'h22222222, 10'h0);
		add_row(enc(6'd14, 5'd0, 5'd0, 16'h0040), 32'h134, 0, 5'd0, 32'h0, 0, 0, 0,
			5'd0, 32'h0, 32'h0, ctrl(1, 0, 0, 0, 2'd3, 4'd0));

		repeat (2) @(posedge clk);
		#5;
		check_idex(-1);
		check("stall", 32'(stall), 32'd0);
		#5 arst_n = 1'b1;

		for (int i = 0; i < row_count; i++)
		begin
			@(posedge clk);
			#5 check_idex(i - 1); // the edge before row 0 latched the all-zero inputs.
			#5;
			instr = t_instr[i];
			pc = t_pc[i];
			wb_en = t_wb_en[i];
			wb_dest = t_wb_dest[i];
			wb_value = t_wb_value[i];
			branch_taken = t_branch[i];
			#50 check("stall", 32'(stall), 32'(t_stall[i]));
		end
		@(posedge clk);
		#5 check_idex(row_count - 1);

		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
source/decode_pkg.sv
source/control_decoder.sv
source/register_file.sv
source/hazard_unit.sv
source/id_stage_reg.sv
source/decode_stage.sv
bench/decode_stage_asserts.sv
bench/decode_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= decode_stage_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
